// ==== common/proc_config.svh ====
// --------------------
// Memory sizes for the single-cycle core
// Depth and index width must agree (words == 2**AW)
// Addresses are byte addresses, so bit 0 is never used as an index
// --------------------
`ifndef PROC_CONFIG_SVH
`define PROC_CONFIG_SVH

// Instruction memory, one 16-bit instruction per word
`define PROC_IMEM_WORDS 64
`define PROC_IMEM_AW    6

// Data memory, 16-bit words only
`define PROC_DMEM_WORDS 64
`define PROC_DMEM_AW    6

`endif

// ==== common/procPkg.sv ====
// --------------------
// ISA types for the 16-bit single-cycle core
// Opcode sits in the top five bits of every format
// Register 0 is an ordinary register
// --------------------
package procPkg;

    typedef enum logic [4:0] {
        OP_HALT  = 5'b00000,
        OP_NOP   = 5'b00001,
        OP_J     = 5'b00100,
        OP_ADDI  = 5'b01000,
        OP_ANDI  = 5'b01011,
        OP_BEQZ  = 5'b01100,
        OP_BNEZ  = 5'b01101,
        OP_BLTZ  = 5'b01110,
        OP_ST    = 5'b10000,
        OP_LD    = 5'b10001,
        OP_RTYPE = 5'b11011
    } opcode_t;

    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_SUB = 2'b01,
        ALU_AND = 2'b10,
        ALU_XOR = 2'b11
    } aluFunct_t;

    // Same 16 bits, three field layouts
    typedef union packed {
        struct packed {
            opcode_t   opcode;
            logic [2:0] rs;
            logic [2:0] rt;
            logic [2:0] rd;
            aluFunct_t funct;
        } rType;
        struct packed {
            opcode_t   opcode;
            logic [2:0] rs;
            logic [2:0] rd;
            logic [4:0] imm;
        } iType;
        struct packed {
            opcode_t    opcode;
            logic [10:0] disp;
        } jType;
    } instr_t;

    typedef struct packed {
        logic      regWrite;
        logic      memRead;
        logic      memWrite;
        logic      memToReg;
        logic      aluSrc;
        logic      branch;
        logic [1:0] branchKind;   // 00 eqz, 01 nez, 10 ltz
        logic      jump;
        logic      halt;
        logic      illegal;
        aluFunct_t aluOp;
    } ctrl_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [15:0] read1Data;
        logic [15:0] read2Data;
        logic [15:0] imm;
        logic [15:0] jumpDisp;
        logic [2:0]  destReg;
    } decoded_t;

    typedef struct packed {
        logic [15:0] aluResult;
        logic [15:0] branchTarget;
        logic [15:0] jumpTarget;
        logic        zero;
        logic        ltz;
    } execResult_t;

    // Trace record and register file write request
    typedef struct packed {
        logic        valid;
        logic [2:0]  regNum;
        logic [15:0] data;
    } regWrite_t;

endpackage

// ==== design/fetch.sv ====
// --------------------
// PC register and instruction memory
// Memory is loaded through the program port while the core is stopped
// Read is combinational, no reset on the array
// --------------------
`timescale 1ns/1ps
`include "proc_config.svh"

module fetch (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      commit,
    input  logic                      progWe,
    input  logic [`PROC_IMEM_AW-1:0]  progAddr,
    input  procPkg::instr_t           progData,
    input  logic [15:0]               nextPc,
    output procPkg::instr_t           instr,
    output logic [15:0]               pcPlus2
);

    logic [15:0] pc;
    procPkg::instr_t imem [`PROC_IMEM_WORDS];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (commit) begin
            pc <= nextPc;
        end
    end

    always_ff @(posedge clk) begin
        if (progWe) begin
            imem[progAddr] <= progData;
        end
    end

    // Byte address, so word index starts at bit 1
    assign instr   = imem[pc[`PROC_IMEM_AW:1]];
    assign pcPlus2 = pc + 16'd2;

endmodule

// ==== design/decode.sv ====
// --------------------
// Control decode, ALU control and register file
// HALT and illegal opcodes become a jump to self so the PC holds
// Register writes land on the clock edge, reads are combinational
// --------------------
`timescale 1ns/1ps

module decode (
    input  logic                clk,
    input  logic                arstN,
    input  procPkg::instr_t     instr,
    input  procPkg::regWrite_t  wbReq,
    output procPkg::decoded_t   dec
);

    logic [15:0] regs [8];
    logic [2:0]  src2;
    logic [15:0] immSigned;
    logic [15:0] immZero;

    assign immSigned = {{11{instr.iType.imm[4]}}, instr.iType.imm};
    assign immZero   = {11'd0, instr.iType.imm};

    // ST reads the stored register from the I-view rd slot
    assign src2 = (instr.iType.opcode == procPkg::OP_ST) ? instr.iType.rd : instr.rType.rt;

    always_comb begin
        dec.ctrl       = '0;
        dec.ctrl.aluOp = procPkg::ALU_ADD;
        dec.read1Data  = regs[instr.rType.rs];
        dec.read2Data  = regs[src2];
        dec.imm        = immSigned;
        dec.jumpDisp   = {{5{instr.jType.disp[10]}}, instr.jType.disp};
        dec.destReg    = instr.iType.rd;

        case (instr.rType.opcode)
            procPkg::OP_RTYPE: begin
                dec.ctrl.regWrite = 1'b1;
                dec.ctrl.aluOp    = instr.rType.funct;
                dec.destReg       = instr.rType.rd;
            end
            procPkg::OP_ADDI: begin
                dec.ctrl.regWrite = 1'b1;
                dec.ctrl.aluSrc   = 1'b1;
            end
            procPkg::OP_ANDI: begin
                dec.ctrl.regWrite = 1'b1;
                dec.ctrl.aluSrc   = 1'b1;
                dec.ctrl.aluOp    = procPkg::ALU_AND;
                dec.imm           = immZero;
            end
            procPkg::OP_LD: begin
                dec.ctrl.regWrite = 1'b1;
                dec.ctrl.memRead  = 1'b1;
                dec.ctrl.memToReg = 1'b1;
                dec.ctrl.aluSrc   = 1'b1;
            end
            procPkg::OP_ST: begin
                dec.ctrl.memWrite = 1'b1;
                dec.ctrl.aluSrc   = 1'b1;
            end
            procPkg::OP_BEQZ: begin
                dec.ctrl.branch     = 1'b1;
                dec.ctrl.branchKind = 2'b00;
            end
            procPkg::OP_BNEZ: begin
                dec.ctrl.branch     = 1'b1;
                dec.ctrl.branchKind = 2'b01;
            end
            procPkg::OP_BLTZ: begin
                dec.ctrl.branch     = 1'b1;
                dec.ctrl.branchKind = 2'b10;
            end
            procPkg::OP_J: begin
                dec.ctrl.jump = 1'b1;
            end
            procPkg::OP_NOP: begin
            end
            procPkg::OP_HALT: begin
                // Displacement of -1 word lands back on this instruction
                dec.ctrl.halt = 1'b1;
                dec.ctrl.jump = 1'b1;
                dec.jumpDisp  = 16'hFFFF;
            end
            default: begin
                dec.ctrl.illegal = 1'b1;
                dec.ctrl.jump    = 1'b1;
                dec.jumpDisp     = 16'hFFFF;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wbReq.valid) begin
            regs[wbReq.regNum] <= wbReq.data;
        end
    end

endmodule

// ==== design/execute.sv ====
// --------------------
// ALU and PC-relative target adders
// Branch and jump offsets count instructions, so they shift by one
// Flags describe the first source, the register a branch tests
// --------------------
`timescale 1ns/1ps

module execute (
    input  procPkg::decoded_t     dec,
    input  logic [15:0]           pcPlus2,
    output procPkg::execResult_t  res
);

    logic [15:0] opA;
    logic [15:0] opB;
    logic [15:0] aluOut;

    assign opA = dec.read1Data;
    assign opB = dec.ctrl.aluSrc ? dec.imm : dec.read2Data;

    always_comb begin
        case (dec.ctrl.aluOp)
            procPkg::ALU_ADD: aluOut = opA + opB;
            procPkg::ALU_SUB: aluOut = opA - opB;
            procPkg::ALU_AND: aluOut = opA & opB;
            procPkg::ALU_XOR: aluOut = opA ^ opB;
            default:          aluOut = opA + opB;
        endcase
    end

    assign res.aluResult    = aluOut;
    assign res.branchTarget = pcPlus2 + {dec.imm[14:0], 1'b0};
    assign res.jumpTarget   = pcPlus2 + {dec.jumpDisp[14:0], 1'b0};

    // Zero and sign of the tested register
    assign res.zero = (dec.read1Data == 16'd0);
    assign res.ltz  = dec.read1Data[15];

endmodule

// ==== design/memory.sv ====
// --------------------
// Data memory and branch decision
// Word access only, address bit 0 ignored
// Stores happen only on a commit edge
// --------------------
`timescale 1ns/1ps
`include "proc_config.svh"

module memory (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  commit,
    input  procPkg::decoded_t     dec,
    input  procPkg::execResult_t  res,
    input  logic [15:0]           pcPlus2,
    output logic [15:0]           readData,
    output logic [15:0]           branchOrPc
);

    logic [15:0] dmem [`PROC_DMEM_WORDS];
    logic [`PROC_DMEM_AW-1:0] wordIdx;
    logic taken;

    assign wordIdx  = res.aluResult[`PROC_DMEM_AW:1];
    assign readData = dec.ctrl.memRead ? dmem[wordIdx] : 16'd0;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `PROC_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (dec.ctrl.memWrite && commit) begin
            dmem[wordIdx] <= dec.read2Data;
        end
    end

    always_comb begin
        case (dec.ctrl.branchKind)
            2'b00:   taken = res.zero;
            2'b01:   taken = !res.zero;
            2'b10:   taken = res.ltz;
            default: taken = 1'b0;
        endcase
    end

    assign branchOrPc = (dec.ctrl.branch && taken) ? res.branchTarget : pcPlus2;

endmodule

// ==== design/writeBack.sv ====
// --------------------
// Result select, next PC and trace record
// Record is only valid while the core commits
// --------------------
`timescale 1ns/1ps

module writeBack (
    input  logic                  commit,
    input  procPkg::decoded_t     dec,
    input  procPkg::execResult_t  res,
    input  logic [15:0]           readData,
    input  logic [15:0]           branchOrPc,
    output procPkg::regWrite_t    wbReq,
    output logic [15:0]           nextPc
);

    assign wbReq.valid  = dec.ctrl.regWrite && commit;
    assign wbReq.regNum = dec.destReg;
    assign wbReq.data   = dec.ctrl.memToReg ? readData : res.aluResult;

    // Jump covers J, HALT and illegal opcodes
    assign nextPc = dec.ctrl.jump ? res.jumpTarget : branchOrPc;

endmodule

// ==== design/proc.sv ====
// --------------------
// Single-cycle 16-bit core, one instruction per clock while run is high
// Load instruction memory with run low
// halted and err are sticky until reset
// --------------------
`timescale 1ns/1ps
`include "proc_config.svh"

module proc (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      run,
    input  logic                      progWe,
    input  logic [`PROC_IMEM_AW-1:0]  progAddr,
    input  procPkg::instr_t           progData,
    output procPkg::regWrite_t        trace,
    output logic                      halted,
    output logic                      err
);

    procPkg::instr_t      instr;
    procPkg::decoded_t    dec;
    procPkg::execResult_t res;
    procPkg::regWrite_t   wbReq;
    logic [15:0]          pcPlus2;
    logic [15:0]          nextPc;
    logic [15:0]          readData;
    logic [15:0]          branchOrPc;
    logic                 commit;

    assign commit = run && !halted && !err;
    assign trace  = wbReq;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            halted <= 1'b0;
            err    <= 1'b0;
        end else if (commit) begin
            halted <= dec.ctrl.halt;
            err    <= dec.ctrl.illegal;
        end
    end

    fetch fetch_inst (
        .clk(clk), .arstN(arstN), .commit(commit),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .nextPc(nextPc), .instr(instr), .pcPlus2(pcPlus2)
    );

    decode decode_inst (
        .clk(clk), .arstN(arstN), .instr(instr), .wbReq(wbReq), .dec(dec)
    );

    execute execute_inst (
        .dec(dec), .pcPlus2(pcPlus2), .res(res)
    );

    memory memory_inst (
        .clk(clk), .arstN(arstN), .commit(commit), .dec(dec), .res(res),
        .pcPlus2(pcPlus2), .readData(readData), .branchOrPc(branchOrPc)
    );

    writeBack writeBack_inst (
        .commit(commit), .dec(dec), .res(res), .readData(readData),
        .branchOrPc(branchOrPc), .wbReq(wbReq), .nextPc(nextPc)
    );

endmodule

// ==== verification/procTb.sv ====
// --------------------
// Directed tests for the single-cycle core
// Expected traces come from an ISA model stepped over the same program
// Trace is sampled mid-cycle, inputs change 1 ns after the rising edge
// --------------------
`timescale 1ns/1ps
`include "proc_config.svh"

module procTb;

    localparam int MaxCycles = 150;
    localparam int NumRuns   = 8;
    localparam int RunCycles = 8 + `PROC_IMEM_WORDS + MaxCycles + 8;

    logic                     clk;
    logic                     arstN;
    logic                     run;
    logic                     progWe;
    logic [`PROC_IMEM_AW-1:0] progAddr;
    procPkg::instr_t          progData;
    procPkg::regWrite_t       trace;
    logic                     halted;
    logic                     err;

    procPkg::instr_t    prog [`PROC_IMEM_WORDS];
    int                 progLen;
    logic [15:0]        modelRegs [8];
    logic [15:0]        modelMem [`PROC_DMEM_WORDS];
    procPkg::regWrite_t expQ [$];
    logic               expHalt;
    logic               expErr;
    logic [31:0]        lcgState;
    int                 valueErrors;
    int                 seqErrors;

    proc proc_inst (
        .clk(clk), .arstN(arstN), .run(run),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .trace(trace), .halted(halted), .err(err)
    );

    always #5 clk = ~clk;

    function automatic logic [15:0] lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[31:16];
    endfunction

    function automatic procPkg::instr_t rInstr(procPkg::aluFunct_t f, int rd, int rs, int rt);
        procPkg::instr_t w;
        w.rType.opcode = procPkg::OP_RTYPE;
        w.rType.rs     = rs[2:0];
        w.rType.rt     = rt[2:0];
        w.rType.rd     = rd[2:0];
        w.rType.funct  = f;
        return w;
    endfunction

    function automatic procPkg::instr_t iInstr(procPkg::opcode_t op, int rd, int rs, int imm);
        procPkg::instr_t w;
        w.iType.opcode = op;
        w.iType.rs     = rs[2:0];
        w.iType.rd     = rd[2:0];
        w.iType.imm    = imm[4:0];
        return w;
    endfunction

    function automatic procPkg::instr_t jInstr(procPkg::opcode_t op, int disp);
        procPkg::instr_t w;
        w.jType.opcode = op;
        w.jType.disp   = disp[10:0];
        return w;
    endfunction

    // Unused words are HALTs carrying their own address in the spare bits
    task automatic clearProgram();
        for (int i = 0; i < `PROC_IMEM_WORDS; i++) begin
            prog[i] = jInstr(procPkg::OP_HALT, i & 63);
        end
        progLen = 0;
    endtask

    task automatic emit(procPkg::instr_t w);
        prog[progLen] = w;
        progLen++;
    endtask

    // Builds v in rd one nibble at a time, shifting by self-adds
    task automatic loadConst(int rd, logic [15:0] v);
        emit(iInstr(procPkg::OP_ANDI, rd, rd, 0));
        emit(iInstr(procPkg::OP_ADDI, rd, rd, int'(v[15:12])));
        for (int n = 2; n >= 0; n--) begin
            repeat (4) emit(rInstr(procPkg::ALU_ADD, rd, rd, rd));
            emit(iInstr(procPkg::OP_ADDI, rd, rd, int'(v[n*4 +: 4])));
        end
    endtask

    task automatic expectWrite(logic [2:0] rd, logic [15:0] value);
        procPkg::regWrite_t rec;
        rec.valid  = 1'b1;
        rec.regNum = rd;
        rec.data   = value;
        modelRegs[rd] = value;
        expQ.push_back(rec);
    endtask

    // ISA reference model, one instruction per step from PC 0
    task automatic runModel();
        logic [15:0]     pc;
        logic [15:0]     nextPc;
        logic [15:0]     a;
        logic [15:0]     b;
        logic [15:0]     immS;
        logic [15:0]     addr;
        procPkg::instr_t w;
        int              steps;
        logic            stop;
        expQ.delete();
        for (int i = 0; i < 8; i++) modelRegs[i] = '0;
        for (int i = 0; i < `PROC_DMEM_WORDS; i++) modelMem[i] = '0;
        expHalt = 1'b0;
        expErr  = 1'b0;
        pc      = '0;
        steps   = 0;
        stop    = 1'b0;
        while (!stop && steps < MaxCycles) begin
            w      = prog[pc[`PROC_IMEM_AW:1]];
            nextPc = pc + 16'd2;
            a      = modelRegs[w.iType.rs];
            immS   = {{11{w.iType.imm[4]}}, w.iType.imm};
            addr   = a + immS;
            case (w.iType.opcode)
                procPkg::OP_RTYPE: begin
                    b = modelRegs[w.rType.rt];
                    case (w.rType.funct)
                        procPkg::ALU_ADD: expectWrite(w.rType.rd, a + b);
                        procPkg::ALU_SUB: expectWrite(w.rType.rd, a - b);
                        procPkg::ALU_AND: expectWrite(w.rType.rd, a & b);
                        default:          expectWrite(w.rType.rd, a ^ b);
                    endcase
                end
                procPkg::OP_ADDI: expectWrite(w.iType.rd, a + immS);
                procPkg::OP_ANDI: expectWrite(w.iType.rd, a & {11'd0, w.iType.imm});
                procPkg::OP_LD:   expectWrite(w.iType.rd, modelMem[addr[`PROC_DMEM_AW:1]]);
                procPkg::OP_ST:   modelMem[addr[`PROC_DMEM_AW:1]] = modelRegs[w.iType.rd];
                procPkg::OP_BEQZ: if (a == 16'd0) nextPc = nextPc + {immS[14:0], 1'b0};
                procPkg::OP_BNEZ: if (a != 16'd0) nextPc = nextPc + {immS[14:0], 1'b0};
                procPkg::OP_BLTZ: if (a[15]) nextPc = nextPc + {immS[14:0], 1'b0};
                procPkg::OP_J: begin
                    nextPc = nextPc + {{5{w.jType.disp[10]}}, w.jType.disp[9:0], 1'b0};
                end
                procPkg::OP_NOP: begin
                end
                procPkg::OP_HALT: begin
                    expHalt = 1'b1;
                    stop    = 1'b1;
                end
                default: begin
                    expErr = 1'b1;
                    stop   = 1'b1;
                end
            endcase
            pc = nextPc;
            steps++;
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        #1;
        arstN  = 1'b0;
        run    = 1'b0;
        progWe = 1'b0;
        repeat (8) @(posedge clk);
        #1 arstN = 1'b1;
    endtask

    task automatic loadProgram();
        progWe = 1'b1;
        for (int i = 0; i < `PROC_IMEM_WORDS; i++) begin
            progAddr = `PROC_IMEM_AW'(i);
            progData = prog[i];
            @(posedge clk);
            #1;
        end
        progWe = 1'b0;
    endtask

    task automatic checkTrace(procPkg::regWrite_t got, procPkg::regWrite_t exp);
        if (got !== exp) begin
            valueErrors++;
            $display("Fail %0t: write r%0d = %h, expected r%0d = %h",
                     $time, got.regNum, got.data, exp.regNum, exp.data);
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        if (got !== exp) begin
            valueErrors++;
            $display("Fail %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    // Runs the loaded program, optionally dropping run for pauseLen cycles
    task automatic runProgram(int pauseAt, int pauseLen);
        int   cyc;
        logic done;
        runModel();
        applyReset();
        loadProgram();
        run  = 1'b1;
        cyc  = 0;
        done = 1'b0;
        while (!done && cyc < MaxCycles) begin
            @(negedge clk);
            if (trace.valid && !run) begin
                seqErrors++;
                $display("Register write to r%0d while run is low at %0t", trace.regNum, $time);
            end else if (trace.valid && expQ.size() == 0) begin
                seqErrors++;
                $display("Register write to r%0d beyond the expected sequence at %0t",
                         trace.regNum, $time);
            end else if (trace.valid) begin
                checkTrace(trace, expQ.pop_front());
            end
            done = halted || err;
            @(posedge clk);
            #1;
            cyc++;
            if (cyc == pauseAt) begin
                run = 1'b0;
            end else if (pauseLen > 0 && cyc == pauseAt + pauseLen) begin
                run = 1'b1;
            end
        end
        if (!done) begin
            seqErrors++;
            $display("Program did not stop within %0d cycles", MaxCycles);
        end
        // Nothing may be written once the core has stopped
        repeat (4) begin
            @(negedge clk);
            if (trace.valid) begin
                seqErrors++;
                $display("Register write to r%0d after the core stopped at %0t",
                         trace.regNum, $time);
            end
        end
        if (expQ.size() != 0) begin
            seqErrors++;
            $display("Trace is missing %0d expected register writes", expQ.size());
        end
        checkFlag("halted", halted, expHalt);
        checkFlag("err", err, expErr);
    endtask

    task automatic testArith();
        repeat (2) begin
            clearProgram();
            loadConst(1, lcgNext());
            loadConst(2, lcgNext());
            emit(rInstr(procPkg::ALU_ADD, 3, 1, 2));
            emit(rInstr(procPkg::ALU_SUB, 4, 1, 2));
            emit(rInstr(procPkg::ALU_AND, 5, 1, 2));
            emit(rInstr(procPkg::ALU_XOR, 6, 1, 2));
            emit(jInstr(procPkg::OP_HALT, 0));
            runProgram(0, 0);
        end
    endtask

    task automatic testImmediate();
        clearProgram();
        emit(iInstr(procPkg::OP_ADDI, 1, 0, -3));
        emit(iInstr(procPkg::OP_ANDI, 2, 1, -10));
        emit(iInstr(procPkg::OP_ADDI, 3, 1, -16));
        emit(iInstr(procPkg::OP_ANDI, 4, 3, 31));
        emit(jInstr(procPkg::OP_HALT, 0));
        runProgram(0, 0);
    endtask

    task automatic testMemory();
        clearProgram();
        emit(iInstr(procPkg::OP_ADDI, 1, 0, 7));
        emit(iInstr(procPkg::OP_ADDI, 2, 0, -5));
        emit(iInstr(procPkg::OP_ADDI, 3, 0, 14));
        emit(iInstr(procPkg::OP_ST, 1, 0, 4));
        emit(iInstr(procPkg::OP_ST, 2, 0, 10));
        emit(iInstr(procPkg::OP_ST, 2, 3, -2));
        emit(iInstr(procPkg::OP_LD, 4, 0, 4));
        emit(iInstr(procPkg::OP_LD, 5, 0, 10));
        emit(iInstr(procPkg::OP_LD, 6, 3, -2));
        emit(iInstr(procPkg::OP_LD, 7, 3, 8));
        emit(jInstr(procPkg::OP_HALT, 0));
        runProgram(0, 0);
    endtask

    task automatic testControlFlow();
        clearProgram();
        emit(iInstr(procPkg::OP_ADDI, 1, 0, 0));
        emit(iInstr(procPkg::OP_BEQZ, 0, 1, 1));
        emit(iInstr(procPkg::OP_ADDI, 2, 0, 1));
        emit(iInstr(procPkg::OP_ADDI, 3, 0, -1));
        emit(iInstr(procPkg::OP_BNEZ, 0, 3, 1));
        emit(iInstr(procPkg::OP_ADDI, 2, 0, 2));
        emit(iInstr(procPkg::OP_BLTZ, 0, 3, 1));
        emit(iInstr(procPkg::OP_ADDI, 2, 0, 3));
        emit(iInstr(procPkg::OP_BEQZ, 0, 3, 1));
        emit(iInstr(procPkg::OP_ADDI, 4, 0, 4));
        emit(iInstr(procPkg::OP_BNEZ, 0, 1, 1));
        emit(iInstr(procPkg::OP_ADDI, 4, 4, 1));
        emit(iInstr(procPkg::OP_BLTZ, 0, 1, 1));
        emit(iInstr(procPkg::OP_ADDI, 4, 4, 1));
        // Count r5 down from 3, J jumps back over itself and the BEQZ
        emit(iInstr(procPkg::OP_ADDI, 5, 0, 3));
        emit(iInstr(procPkg::OP_ADDI, 5, 5, -1));
        emit(iInstr(procPkg::OP_BEQZ, 0, 5, 1));
        emit(jInstr(procPkg::OP_J, -3));
        emit(jInstr(procPkg::OP_HALT, 0));
        runProgram(0, 0);
    endtask

    task automatic testHaltAndRun();
        clearProgram();
        emit(iInstr(procPkg::OP_ADDI, 1, 0, 5));
        emit(iInstr(procPkg::OP_ADDI, 2, 1, 6));
        emit(iInstr(procPkg::OP_ST, 2, 0, 2));
        emit(iInstr(procPkg::OP_LD, 3, 0, 2));
        emit(rInstr(procPkg::ALU_XOR, 4, 3, 1));
        emit(iInstr(procPkg::OP_ADDI, 5, 4, -1));
        emit(rInstr(procPkg::ALU_SUB, 6, 5, 2));
        emit(jInstr(procPkg::OP_HALT, 0));
        emit(iInstr(procPkg::OP_ADDI, 7, 0, 1));
        runProgram(3, 5);
        applyReset();
        @(negedge clk);
        checkFlag("halted after reset", halted, 1'b0);
    endtask

    task automatic testIllegal();
        clearProgram();
        emit(iInstr(procPkg::OP_ADDI, 1, 0, 9));
        emit(iInstr(procPkg::OP_ADDI, 2, 1, 3));
        emit(jInstr(procPkg::opcode_t'(5'h1F), 0));
        emit(iInstr(procPkg::OP_ADDI, 3, 0, 1));
        emit(jInstr(procPkg::OP_HALT, 0));
        runProgram(0, 0);
        applyReset();
        @(negedge clk);
        checkFlag("err after reset", err, 1'b0);
    endtask

    // Backstop in case a run never reaches its end
    initial begin
        #(NumRuns * RunCycles * 20 + 2000);
        $display("Timeout, simulation did not finish in time");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        arstN       = 1'b0;
        run         = 1'b0;
        progWe      = 1'b0;
        progAddr    = '0;
        progData    = '0;
        lcgState    = 32'ha4e7;
        valueErrors = 0;
        seqErrors   = 0;
        testArith();
        testImmediate();
        testMemory();
        testControlFlow();
        testHaltAndRun();
        testIllegal();
        $display("Checks done: %0d value errors, %0d sequence errors", valueErrors, seqErrors);
        if (valueErrors + seqErrors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== proc.f ====
+incdir+common
common/procPkg.sv
design/fetch.sv
design/decode.sv
design/execute.sv
design/memory.sv
design/writeBack.sv
design/proc.sv
verification/procTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
TOP       := procTb
FILELIST  := proc.f
BUILD     := obj_dir
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST)) common/proc_config.svh

.PHONY: compile run clean

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
